//--- src.f
hdl/pcap_pkg.sv
hdl/stream_snooper.sv
hdl/width_adapter.sv
hdl/packet_mem.sv
hdl/capture_regs.sv
hdl/pcap_top.sv
testbench/tb_pcap_top.sv

//--- Makefile
SIM       = verilator
SIMFLAGS  = --binary --timing -j 0
TOP       = tb_pcap_top
FILELIST  = src.f
PASS_MSG  = PASS: all tests

OBJDIR    = obj_dir
BIN       = $(OBJDIR)/V$(TOP)
SOURCES   = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(BIN)

# Rebuild only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(SIMFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_MSG)$$"

clean:
	rm -rf $(OBJDIR)

//--- testbench/tb_pcap_top.sv
`timescale 1ns/1ps

module tb_pcap_top
    import pcap_pkg::*;
;

    localparam int          CLK_HALF     = 20;
    localparam int          DRIVE_DLY    = 2;
    localparam int          RESET_CYCLES = 3;
    localparam int          IDLE_CYCLES  = 10;
    localparam int          CAP_WORDS    = MAX_PKT_BYTES / 4;
    localparam logic [31:0] LFSR_SEED    = 32'h99f6_2b40;
    localparam logic [31:0] LFSR_TAPS    = 32'h8020_0003;

    typedef struct packed {
        logic        arm_before;
        logic        arm_mid;
        logic [11:0] n_words;
        byte_cnt_t   last_bytes;
        pkt_len_t    exp_len;
        logic        exp_trunc;
        logic        exp_capture;
    } test_entry_t;

    localparam int NUM_TESTS = 8;

    // arm_before, arm_mid, words, last bytes, length, truncated, captured
    localparam test_entry_t TESTS [NUM_TESTS] = '{
        '{1'b1, 1'b0, 12'd7,    4'd3, 13'd27,   1'b0, 1'b1},
        '{1'b0, 1'b0, 12'd5,    4'd4, 13'd0,    1'b0, 1'b0},
        '{1'b0, 1'b1, 12'd9,    4'd2, 13'd0,    1'b0, 1'b0},
        '{1'b0, 1'b0, 12'd6,    4'd1, 13'd21,   1'b0, 1'b1},
        '{1'b1, 1'b0, 12'd1100, 4'd4, 13'd4096, 1'b1, 1'b1},
        '{1'b1, 1'b0, 12'd4,    4'd2, 13'd14,   1'b0, 1'b1},
        '{1'b1, 1'b1, 12'd12,   4'd4, 13'd48,   1'b0, 1'b1},
        '{1'b1, 1'b0, 12'd1,    4'd1, 13'd1,    1'b0, 1'b1}
    };

    logic         clk;
    logic         rst;
    logic         in_valid;
    stream_word_t in_data;
    logic         in_last;
    byte_cnt_t    in_nbytes;
    logic         host_wr;
    logic         host_rd;
    reg_addr_t    host_addr;
    reg_data_t    host_wdata;
    mem_addr_t    rd_addr;
    reg_data_t    host_rdata;
    mem_word_t    rd_data;

    // Expected register state
    logic         model_armed;
    logic         model_ready;
    logic         model_trunc;
    pkt_len_t     model_len;

    stream_word_t captured [CAP_WORDS];
    logic [31:0]  lfsr_state;
    test_entry_t  entry;

    pcap_top i_dut (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .in_data    (in_data),
        .in_last    (in_last),
        .in_nbytes  (in_nbytes),
        .host_wr    (host_wr),
        .host_rd    (host_rd),
        .host_addr  (host_addr),
        .host_wdata (host_wdata),
        .rd_addr    (rd_addr),
        .host_rdata (host_rdata),
        .rd_data    (rd_data)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return (s >> 1) ^ (s[0] ? LFSR_TAPS : 32'h0);
    endfunction

    // One LFSR step per data bit
    function automatic stream_word_t random_word();
        stream_word_t w;
        w = '0;
        for (int b = 0; b < 32; b++) begin
            w          = {w[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return w;
    endfunction

    function automatic int watchdog_cycles();
        int total;
        total = RESET_CYCLES;
        for (int i = 0; i < NUM_TESTS; i++) begin
            total += int'(TESTS[i].n_words) + 200;
        end
        return total;
    endfunction

    task automatic fail_run();
        $display("FAIL: see errors above");
        $fatal(1, "simulation stopped after an error");
    endtask

    task automatic check_reg(input string name, input reg_data_t got, input reg_data_t exp);
        if (got !== exp) begin
            $display("ERROR: time %0t %s got %h expected %h", $time, name, got, exp);
            fail_run();
        end
    endtask

    // Mask bit k covers bits 8k+7:8k of the line
    task automatic check_line(input string name, input mem_word_t got, input mem_word_t exp,
                              input logic [7:0] mask);
        logic bad;
        bad = 1'b0;
        for (int k = 0; k < 8; k++) begin
            if (mask[k] && (got[8*k +: 8] !== exp[8*k +: 8])) begin
                bad = 1'b1;
            end
        end
        if (bad) begin
            $display("ERROR: time %0t %s got %h expected %h byte mask %b",
                     $time, name, got, exp, mask);
            fail_run();
        end
    endtask

    // An arm write only counts while no capture is pending
    task automatic apply_arm();
        if (!model_armed) begin
            model_armed = 1'b1;
            model_ready = 1'b0;
            model_trunc = 1'b0;
            model_len   = '0;
        end
    endtask

    task automatic arm_capture();
        @(posedge clk);
        #DRIVE_DLY;
        host_wr    = 1'b1;
        host_addr  = REG_CTRL;
        host_wdata = 16'h0001;
        apply_arm();
        @(posedge clk);
        #DRIVE_DLY;
        host_wr    = 1'b0;
        host_wdata = '0;
    endtask

    task automatic read_reg(input reg_addr_t addr, output reg_data_t data);
        @(posedge clk);
        #DRIVE_DLY;
        host_rd   = 1'b1;
        host_addr = addr;
        @(posedge clk);
        #DRIVE_DLY;
        host_rd   = 1'b0;
        data      = host_rdata;
    endtask

    task automatic check_status_regs();
        reg_data_t got;
        read_reg(REG_STATUS, got);
        check_reg("STATUS", got, {13'd0, model_armed, model_trunc, model_ready});
        read_reg(REG_LENGTH, got);
        check_reg("LENGTH", got, reg_data_t'(model_len));
    endtask

    task automatic send_packet(input test_entry_t t);
        stream_word_t data;
        logic         last;
        for (int w = 0; w < int'(t.n_words); w++) begin
            @(posedge clk);
            #DRIVE_DLY;
            data      = random_word();
            last      = (w == int'(t.n_words) - 1);
            in_valid  = 1'b1;
            in_data   = data;
            in_last   = last;
            in_nbytes = last ? t.last_bytes : 4'd4;
            // Arm write lands alongside the fourth word
            if (t.arm_mid && w == 3) begin
                host_wr    = 1'b1;
                host_addr  = REG_CTRL;
                host_wdata = 16'h0001;
                apply_arm();
            end else begin
                host_wr    = 1'b0;
                host_wdata = '0;
            end
            if (t.exp_capture && w < CAP_WORDS) begin
                captured[w] = data;
            end
        end
        @(posedge clk);
        #DRIVE_DLY;
        in_valid  = 1'b0;
        in_last   = 1'b0;
        in_nbytes = '0;
        host_wr   = 1'b0;
        repeat (IDLE_CYCLES) @(posedge clk);
    endtask

    // Pipelined readback checks line i-1 while line i is addressed
    task automatic check_memory(input test_entry_t t);
        int           n_cap;
        int           n_lines;
        int           l;
        mem_word_t    exp;
        logic [7:0]   mask;
        n_cap   = (int'(t.n_words) < CAP_WORDS) ? int'(t.n_words) : CAP_WORDS;
        n_lines = (n_cap + 1) / 2;
        for (int i = 0; i <= n_lines; i++) begin
            @(posedge clk);
            #DRIVE_DLY;
            if (i > 0) begin
                l           = i - 1;
                exp[63:32]  = captured[2*l];
                exp[31:0]   = (2*l + 1 < n_cap) ? captured[2*l + 1] : '0;
                for (int k = 0; k < 8; k++) begin
                    mask[k] = (8*l + 7 - k) < int'(t.exp_len);
                end
                check_line($sformatf("rd_data[%0d]", l), rd_data, exp, mask);
            end
            if (i < n_lines) begin
                rd_addr = mem_addr_t'(i);
            end
        end
    endtask

    initial begin
        int limit;
        limit = watchdog_cycles();
        repeat (limit) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", limit);
        fail_run();
    end

    initial begin
        rst         = 1'b1;
        in_valid    = 1'b0;
        in_data     = '0;
        in_last     = 1'b0;
        in_nbytes   = '0;
        host_wr     = 1'b0;
        host_rd     = 1'b0;
        host_addr   = '0;
        host_wdata  = '0;
        rd_addr     = '0;
        model_armed = 1'b0;
        model_ready = 1'b0;
        model_trunc = 1'b0;
        model_len   = '0;
        lfsr_state  = LFSR_SEED;

        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DLY;
        rst = 1'b0;

        for (int t = 0; t < NUM_TESTS; t++) begin
            entry = TESTS[t];
            if (entry.arm_before) begin
                arm_capture();
                check_status_regs();
            end
            send_packet(entry);
            if (entry.exp_capture) begin
                model_armed = 1'b0;
                model_ready = 1'b1;
                model_trunc = entry.exp_trunc;
                model_len   = entry.exp_len;
            end
            check_status_regs();
            if (entry.exp_capture) begin
                check_memory(entry);
            end
        end

        $display("PASS: all tests");
        $finish;
    end

endmodule

//--- hdl/pcap_top.sv
`timescale 1ns/1ps

module pcap_top
    import pcap_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         in_valid,
    input  stream_word_t in_data,
    input  logic         in_last,
    input  byte_cnt_t    in_nbytes,
    input  logic         host_wr,
    input  logic         host_rd,
    input  reg_addr_t    host_addr,
    input  reg_data_t    host_wdata,
    input  mem_addr_t    rd_addr,
    output reg_data_t    host_rdata,
    output mem_word_t    rd_data
);

    // Snooper to adapter
    word_addr_t   word_addr;
    stream_word_t word_data;
    logic         word_wr;
    byte_cnt_t    word_bytes;
    logic         word_done;
    logic         trunc;

    // Adapter to memory and registers
    mem_addr_t    mem_addr;
    mem_word_t    mem_data;
    logic         mem_wr;
    byte_cnt_t    line_bytes;
    logic         line_done;

    logic         armed;

    stream_snooper i_snooper (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .in_data    (in_data),
        .in_last    (in_last),
        .in_nbytes  (in_nbytes),
        .armed      (armed),
        .word_addr  (word_addr),
        .word_data  (word_data),
        .word_wr    (word_wr),
        .word_bytes (word_bytes),
        .word_done  (word_done),
        .trunc      (trunc)
    );

    capture_regs i_regs (
        .clk        (clk),
        .rst        (rst),
        .host_wr    (host_wr),
        .host_rd    (host_rd),
        .host_addr  (host_addr),
        .host_wdata (host_wdata),
        .line_bytes (line_bytes),
        .mem_wr     (mem_wr),
        .line_done  (line_done),
        .trunc      (trunc),
        .host_rdata (host_rdata),
        .armed      (armed)
    );

    width_adapter i_adapter (
        .clk        (clk),
        .rst        (rst),
        .word_addr  (word_addr),
        .word_data  (word_data),
        .word_wr    (word_wr),
        .word_bytes (word_bytes),
        .word_done  (word_done),
        .mem_addr   (mem_addr),
        .mem_data   (mem_data),
        .mem_wr     (mem_wr),
        .line_bytes (line_bytes),
        .line_done  (line_done)
    );

    packet_mem i_mem (
        .clk        (clk),
        .mem_addr   (mem_addr),
        .mem_data   (mem_data),
        .mem_wr     (mem_wr),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data)
    );

endmodule

//--- hdl/capture_regs.sv
`timescale 1ns/1ps

module capture_regs
    import pcap_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      host_wr,
    input  logic      host_rd,
    input  reg_addr_t host_addr,
    input  reg_data_t host_wdata,
    input  byte_cnt_t line_bytes,
    input  logic      mem_wr,
    input  logic      line_done,
    input  logic      trunc,
    output reg_data_t host_rdata,
    output logic      armed
);

    logic      ready;
    logic      truncated;
    pkt_len_t  length;
    pkt_len_t  run_len;
    pkt_len_t  line_len;
    logic      arm_req;
    reg_data_t status_word;

    assign arm_req  = host_wr && (host_addr == REG_CTRL) && host_wdata[0];
    assign line_len = pkt_len_t'(line_bytes);

    always_ff @(posedge clk) begin
        if (rst) begin
            armed     <= 1'b0;
            ready     <= 1'b0;
            truncated <= 1'b0;
            length    <= '0;
            run_len   <= '0;
        end else if (armed) begin
            if (line_done) begin
                // Capture complete, publish the results
                armed     <= 1'b0;
                ready     <= 1'b1;
                truncated <= trunc;
                length    <= run_len + line_len;
            end else if (mem_wr) begin
                run_len <= run_len + line_len;
            end
        end else if (arm_req) begin
            armed     <= 1'b1;
            ready     <= 1'b0;
            truncated <= 1'b0;
            length    <= '0;
            run_len   <= '0;
        end
    end

    always_comb begin
        status_word             = '0;
        status_word[STAT_READY] = ready;
        status_word[STAT_TRUNC] = truncated;
        status_word[STAT_ARMED] = armed;
    end

    // Registered read data, CTRL and unused addresses read as zero
    always_ff @(posedge clk) begin
        if (rst) begin
            host_rdata <= '0;
        end else if (host_rd) begin
            case (host_addr)
                REG_STATUS: host_rdata <= status_word;
                REG_LENGTH: host_rdata <= reg_data_t'(length);
                default:    host_rdata <= '0;
            endcase
        end
    end

endmodule

//--- hdl/packet_mem.sv
`timescale 1ns/1ps

module packet_mem
    import pcap_pkg::*;
(
    input  logic      clk,
    input  mem_addr_t mem_addr,
    input  mem_word_t mem_data,
    input  logic      mem_wr,
    input  mem_addr_t rd_addr,
    output mem_word_t rd_data
);

    mem_word_t mem [MEM_DEPTH];

    // Write port from the width adapter
    always_ff @(posedge clk) begin
        if (mem_wr) begin
            mem[mem_addr] <= mem_data;
        end
    end

    // Host readback, one cycle latency
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

//--- hdl/width_adapter.sv
`timescale 1ns/1ps

module width_adapter
    import pcap_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  word_addr_t   word_addr,
    input  stream_word_t word_data,
    input  logic         word_wr,
    input  byte_cnt_t    word_bytes,
    input  logic         word_done,
    output mem_addr_t    mem_addr,
    output mem_word_t    mem_data,
    output logic         mem_wr,
    output byte_cnt_t    line_bytes,
    output logic         line_done
);

    logic [LANE_W-1:0] lane;
    stream_word_t      line_q [WORDS_PER_LINE];
    stream_word_t      line_n [WORDS_PER_LINE];
    byte_cnt_t         acc;

    // Word offset within the memory line
    assign lane = word_addr[LANE_W-1:0];

    // Lane 0 of the address maps to the top of the line, so the
    // earlier stream word lands in the upper half
    for (genvar i = 0; i < WORDS_PER_LINE; i++) begin : g_lane
        assign line_n[i] = (int'(lane) == WORDS_PER_LINE - 1 - i) ? word_data : line_q[i];
        assign mem_data[(i + 1) * STREAM_W - 1 -: STREAM_W] = line_n[i];

        always_ff @(posedge clk) begin
            if (word_wr) begin
                line_q[i] <= line_n[i];
            end
        end
    end

    assign mem_addr = word_addr[WORD_ADDR_W-1:LANE_W];

    // Flush on the last lane, or early when the packet ends mid-line
    assign mem_wr = word_wr && ((&lane) || word_done);

    assign line_done = word_done;

    // Byte count of the line being built
    always_ff @(posedge clk) begin
        if (rst || mem_wr) begin
            acc <= '0;
        end else if (word_wr) begin
            acc <= acc + word_bytes;
        end
    end

    assign line_bytes = acc + word_bytes;

endmodule

//--- hdl/stream_snooper.sv
`timescale 1ns/1ps

module stream_snooper
    import pcap_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         in_valid,
    input  stream_word_t in_data,
    input  logic         in_last,
    input  byte_cnt_t    in_nbytes,
    input  logic         armed,
    output word_addr_t   word_addr,
    output stream_word_t word_data,
    output logic         word_wr,
    output byte_cnt_t    word_bytes,
    output logic         word_done,
    output logic         trunc
);

    snoop_state_t state;
    word_addr_t   next_addr;
    logic         start_ok;
    logic         at_end;

    // armed is still high in the cycle right after the final word,
    // so a packet that follows back to back must not restart a capture
    assign start_ok = armed && !word_done;

    // Memory full once this word is written
    assign at_end = (next_addr == LAST_WORD_ADDR);

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= IDLE;
            next_addr <= '0;
            word_wr   <= 1'b0;
            word_done <= 1'b0;
            trunc     <= 1'b0;
        end else begin
            word_wr   <= 1'b0;
            word_done <= 1'b0;
            trunc     <= 1'b0;
            if (in_valid) begin
                case (state)
                    IDLE: begin
                        if (start_ok) begin
                            // First word of the capture goes to address 0
                            word_wr   <= 1'b1;
                            next_addr <= word_addr_t'(1);
                            if (in_last) begin
                                word_done <= 1'b1;
                            end else begin
                                state <= CAPTURE;
                            end
                        end else if (!in_last) begin
                            state <= SKIP;
                        end
                    end
                    SKIP: begin
                        if (in_last) begin
                            state <= IDLE;
                        end
                    end
                    CAPTURE: begin
                        word_wr   <= 1'b1;
                        next_addr <= next_addr + 1'b1;
                        if (in_last) begin
                            word_done <= 1'b1;
                            state     <= IDLE;
                        end else if (at_end) begin
                            // Out of room, close the capture here
                            word_done <= 1'b1;
                            trunc     <= 1'b1;
                            state     <= DRAIN;
                        end
                    end
                    DRAIN: begin
                        if (in_last) begin
                            state <= IDLE;
                        end
                    end
                    default: begin
                        state <= IDLE;
                    end
                endcase
            end
        end
    end

    // Payload of the write, qualified by word_wr
    always_ff @(posedge clk) begin
        if (in_valid) begin
            word_addr  <= (state == IDLE) ? '0 : next_addr;
            word_data  <= in_data;
            word_bytes <= in_nbytes;
        end
    end

endmodule

//--- hdl/pcap_pkg.sv
package pcap_pkg;

    // Stream and memory geometry
    localparam int STREAM_W       = 32;
    localparam int WORDS_PER_LINE = 2;
    localparam int MEM_W          = STREAM_W * WORDS_PER_LINE;
    localparam int WORD_ADDR_W    = 10;
    localparam int MEM_ADDR_W     = 9;
    localparam int LANE_W         = WORD_ADDR_W - MEM_ADDR_W;
    localparam int MEM_DEPTH      = 2 ** MEM_ADDR_W;
    localparam int BYTES_PER_WORD = STREAM_W / 8;
    localparam int MAX_PKT_BYTES  = 4096;
    localparam int BYTE_CNT_W     = 4;
    localparam int PKT_LEN_W      = 13;
    localparam int REG_ADDR_W     = 2;
    localparam int REG_DATA_W     = 16;

    typedef logic [STREAM_W-1:0]    stream_word_t;
    typedef logic [MEM_W-1:0]       mem_word_t;
    typedef logic [WORD_ADDR_W-1:0] word_addr_t;
    typedef logic [MEM_ADDR_W-1:0]  mem_addr_t;
    typedef logic [BYTE_CNT_W-1:0]  byte_cnt_t;
    typedef logic [PKT_LEN_W-1:0]   pkt_len_t;
    typedef logic [REG_ADDR_W-1:0]  reg_addr_t;
    typedef logic [REG_DATA_W-1:0]  reg_data_t;

    // Last stream word that still fits in the packet memory
    localparam word_addr_t LAST_WORD_ADDR = word_addr_t'(MAX_PKT_BYTES / BYTES_PER_WORD - 1);

    // Host register map
    localparam reg_addr_t REG_CTRL   = 2'd0;
    localparam reg_addr_t REG_STATUS = 2'd1;
    localparam reg_addr_t REG_LENGTH = 2'd2;

    // STATUS bit positions
    localparam int STAT_READY = 0;
    localparam int STAT_TRUNC = 1;
    localparam int STAT_ARMED = 2;

    typedef enum logic [1:0] {
        IDLE,
        SKIP,
        CAPTURE,
        DRAIN
    } snoop_state_t;

endpackage
